/* vlog.f */
+incdir+.
dma_axi_pkg.sv
dma_pkt_queue.sv
axi_burst_ctrl.sv
axi_write_beats.sv
axi_read_beats.sv
dma_axi_top.sv
tb_clk_gen.sv
dma_axi_assert.sv
dma_axi_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dma_axi_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dma_axi_tb.sv */
// Bridge testbench with AXI slave memory model
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module dma_axi_tb;
   import dma_axi_pkg::*;

   localparam int N_ENT = 8;
   localparam int MEM_WORDS = 512;
   localparam int LIMIT = N_ENT * 60 + 100;

   logic                  clk, rst_n;
   logic                  dma_pkt_v_i, dma_pkt_write_not_read_i;
   dram_addr_u            dma_pkt_addr_i;
   logic [`DA_BEATS-1:0]  dma_pkt_mask_i;
   logic                  dma_pkt_ready_o;
   logic                  dma_wdata_v_i, dma_wdata_ready_o;
   logic [`DA_DATA_W-1:0] dma_wdata_i, dma_rdata_o, m_axi_wdata_o, m_axi_rdata_i;
   logic                  dma_rdata_v_o, dma_rdata_ready_i, err_o;
   logic [`DA_ADDR_W-1:0] m_axi_awaddr_o, m_axi_araddr_o;
   logic                  m_axi_awvalid_o, m_axi_awready_i, m_axi_arvalid_o, m_axi_arready_i;
   logic [`DA_STRB_W-1:0] m_axi_wstrb_o;
   logic                  m_axi_wlast_o, m_axi_wvalid_o, m_axi_wready_i;
   logic [1:0]            m_axi_bresp_i, m_axi_rresp_i;
   logic                  m_axi_bvalid_i, m_axi_bready_o;
   logic                  m_axi_rlast_i, m_axi_rvalid_i, m_axi_rready_o;

   // Stimulus table of kind, address, mask, data seed and slave response
   logic                  tbl_wnr  [N_ENT];
   dram_addr_u            tbl_addr [N_ENT];
   logic [`DA_BEATS-1:0]  tbl_mask [N_ENT];
   logic [31:0]           tbl_seed [N_ENT];
   logic [1:0]            tbl_resp [N_ENT];

   logic [`DA_DATA_W-1:0] mem     [MEM_WORDS];
   logic [`DA_DATA_W-1:0] exp_mem [MEM_WORDS];
   logic [`DA_DATA_W-1:0] exp_rd_q [$];
   integer                seed = 32'hcfae21ed;
   int                    bursts_done, reads_done, cycles;
   int                    accepted, addr_started;
   bit                    bad_seen, addr_v_d;

   tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

   dma_axi_top dma_axi_top_inst (.clk_i(clk), .rst_n_i(rst_n), .*);

   task automatic check_addr(string name, dram_addr_u exp_v, dram_addr_u got_v);
      if (exp_v !== got_v)
      begin
         $display("mismatch %s exp %h got %h", name, exp_v.flat, got_v.flat);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_beat(string name, logic [`DA_DATA_W-1:0] exp_v,
                             logic [`DA_DATA_W-1:0] got_v);
      if (exp_v !== got_v)
      begin
         $display("mismatch %s exp %h got %h", name, exp_v, got_v);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_strb(string name, logic [`DA_STRB_W-1:0] exp_v,
                             logic [`DA_STRB_W-1:0] got_v);
      if (exp_v !== got_v)
      begin
         $display("mismatch %s exp %h got %h", name, exp_v, got_v);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(string name, bit exp_v, logic got_v);
      if (got_v !== exp_v)
      begin
         $display("mismatch %s exp %h got %h", name, exp_v, got_v);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   // Bank field XOR low row bits, offset cleared
   function automatic dram_addr_u expect_addr(dram_addr_u a);
      dram_addr_u r;
      r.flat = {a.flat[27:9], a.flat[8:6] ^ a.flat[11:9], 6'b0};
      return r;
   endfunction

   function automatic logic [`DA_DATA_W-1:0] beat_data(logic [31:0] s, int k);
      return {s ^ (32'h9e3779b9 * (k + 1)), ~s + k};
   endfunction

   function automatic int word_index(logic [`DA_ADDR_W-1:0] flat);
      return int'(flat >> 3) % MEM_WORDS;
   endfunction

   task automatic fill_table(int i, logic wnr, logic [27:0] a, logic [7:0] m,
                             logic [31:0] s, logic [1:0] resp);
      tbl_wnr[i]       = wnr;
      tbl_addr[i].flat = a;
      tbl_mask[i]      = m;
      tbl_seed[i]      = s;
      tbl_resp[i]      = resp;
   endtask

   initial
   begin
      int base;
      dma_pkt_v_i              = 1'b0;
      dma_pkt_write_not_read_i = 1'b0;
      dma_pkt_addr_i           = '0;
      dma_pkt_mask_i           = '0;
      dma_wdata_v_i            = 1'b0;
      dma_wdata_i              = '0;
      dma_rdata_ready_i        = 1'b0;
      m_axi_awready_i          = 1'b0;
      m_axi_wready_i           = 1'b0;
      m_axi_bresp_i            = '0;
      m_axi_bvalid_i           = 1'b0;
      m_axi_arready_i          = 1'b0;
      m_axi_rdata_i            = '0;
      m_axi_rresp_i            = '0;
      m_axi_rlast_i            = 1'b0;
      m_axi_rvalid_i           = 1'b0;
      fill_table(0, 1, 28'h00003d5, 8'ha5, 32'h11110001, 2'b00);
      fill_table(1, 0, 28'h00003d5, 8'h00, 32'h0, 2'b00);
      fill_table(2, 1, 28'h00005a8, 8'hff, 32'h22220002, 2'b00);
      fill_table(3, 0, 28'h00005a8, 8'h00, 32'h0, 2'b00);
      fill_table(4, 1, 28'h00012c0, 8'h0f, 32'h33330003, 2'b00);
      fill_table(5, 0, 28'h00012c0, 8'h00, 32'h0, 2'b00);
      fill_table(6, 1, 28'h000007c, 8'h3c, 32'h44440004, 2'b10);
      fill_table(7, 0, 28'h000007c, 8'h00, 32'h0, 2'b10);
      for (int w = 0; w < MEM_WORDS; w++)
      begin
         mem[w]     = {$random(seed), $random(seed)};
         exp_mem[w] = mem[w];
      end
      // Expected read data follows table order
      for (int i = 0; i < N_ENT; i++)
      begin
         base = word_index(expect_addr(tbl_addr[i]));
         for (int k = 0; k < `DA_BEATS; k++)
            if (!tbl_wnr[i])
               exp_rd_q.push_back(exp_mem[base + k]);
            else if (tbl_mask[i][k])
               exp_mem[base + k] = beat_data(tbl_seed[i], k);
      end
   end

   // Packet poster
   initial
   begin
      wait (rst_n === 1'b1);
      @(posedge clk);
      check_flag("dma_pkt_ready_o", 1'b1, dma_pkt_ready_o);
      check_flag("dma_rdata_v_o", 1'b0, dma_rdata_v_o);
      check_flag("m_axi_wvalid_o", 1'b0, m_axi_wvalid_o);
      check_flag("m_axi_awvalid_o", 1'b0, m_axi_awvalid_o);
      check_flag("m_axi_arvalid_o", 1'b0, m_axi_arvalid_o);
      check_flag("m_axi_bready_o", 1'b0, m_axi_bready_o);
      for (int i = 0; i < N_ENT; i++)
      begin
         dma_pkt_v_i              <= 1'b1;
         dma_pkt_write_not_read_i <= tbl_wnr[i];
         dma_pkt_addr_i           <= tbl_addr[i];
         dma_pkt_mask_i           <= tbl_mask[i];
         @(posedge clk);
         while (!dma_pkt_ready_o)
            @(posedge clk);
      end
      dma_pkt_v_i <= 1'b0;
   end

   // Write data feeder
   initial
   begin
      wait (rst_n === 1'b1);
      for (int i = 0; i < N_ENT; i++)
      begin
         for (int k = 0; k < `DA_BEATS && tbl_wnr[i]; k++)
         begin
            dma_wdata_v_i <= 1'b1;
            dma_wdata_i   <= beat_data(tbl_seed[i], k);
            @(posedge clk);
            while (!dma_wdata_ready_o)
               @(posedge clk);
         end
      end
      dma_wdata_v_i <= 1'b0;
   end

   // Read data consumer with random ready
   initial
   begin
      wait (rst_n === 1'b1);
      while (exp_rd_q.size() > 0)
      begin
         @(posedge clk);
         if (dma_rdata_v_o && dma_rdata_ready_i)
            check_beat("dma_rdata_o", exp_rd_q.pop_front(), dma_rdata_o);
         dma_rdata_ready_i <= (($random(seed) & 3) != 0);
      end
      dma_rdata_ready_i <= 1'b0;
      reads_done = 1;
   end

   // AXI slave memory
   initial
   begin
      int base, k;
      wait (rst_n === 1'b1);
      while (bursts_done < N_ENT)
      begin
         @(posedge clk);
         if (m_axi_awvalid_o && m_axi_awready_i)
         begin
            m_axi_awready_i <= 1'b0;
            check_addr("m_axi_awaddr_o", expect_addr(tbl_addr[bursts_done]), m_axi_awaddr_o);
            base = word_index(m_axi_awaddr_o);
            k = 0;
            while (k < `DA_BEATS)
            begin
               @(posedge clk);
               check_flag("dma_wdata_ready_o", m_axi_wready_i, dma_wdata_ready_o);
               check_flag("m_axi_bready_o", 1'b0, m_axi_bready_o);
               if (m_axi_wvalid_o && m_axi_wready_i)
               begin
                  check_beat("m_axi_wdata_o", beat_data(tbl_seed[bursts_done], k),
                             m_axi_wdata_o);
                  check_strb("m_axi_wstrb_o", {`DA_STRB_W{tbl_mask[bursts_done][k]}},
                             m_axi_wstrb_o);
                  check_flag("m_axi_wlast_o", k == `DA_BEATS - 1, m_axi_wlast_o);
                  for (int b = 0; b < `DA_STRB_W; b++)
                     if (m_axi_wstrb_o[b])
                        mem[base + k][8*b +: 8] = m_axi_wdata_o[8*b +: 8];
                  k++;
               end
               m_axi_wready_i <= (k < `DA_BEATS) && (($random(seed) & 3) != 0);
            end
            m_axi_wready_i <= 1'b0;
            m_axi_bvalid_i <= 1'b1;
            m_axi_bresp_i  <= tbl_resp[bursts_done];
            @(posedge clk);
            while (!m_axi_bready_o)
               @(posedge clk);
            m_axi_bvalid_i <= 1'b0;
            bursts_done++;
         end
         else if (m_axi_arvalid_o && m_axi_arready_i)
         begin
            m_axi_arready_i <= 1'b0;
            check_addr("m_axi_araddr_o", expect_addr(tbl_addr[bursts_done]), m_axi_araddr_o);
            base = word_index(m_axi_araddr_o);
            for (k = 0; k < `DA_BEATS; k++)
            begin
               m_axi_rvalid_i <= 1'b1;
               m_axi_rdata_i  <= mem[base + k];
               m_axi_rlast_i  <= (k == `DA_BEATS - 1);
               m_axi_rresp_i  <= tbl_resp[bursts_done];
               @(posedge clk);
               while (!m_axi_rready_o)
                  @(posedge clk);
            end
            m_axi_rvalid_i <= 1'b0;
            m_axi_rlast_i  <= 1'b0;
            bursts_done++;
         end
         else
         begin
            m_axi_awready_i <= (($random(seed) & 1) != 0);
            m_axi_arready_i <= (($random(seed) & 1) != 0);
         end
      end
   end

   // Per-cycle monitor and timeout
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         check_flag("err_o", bad_seen, err_o);
         check_flag("aw_and_ar_valid", 1'b0, m_axi_awvalid_o & m_axi_arvalid_o);
         // Head leaves the queue the cycle before its address goes valid
         if ((m_axi_awvalid_o || m_axi_arvalid_o) && !addr_v_d)
            addr_started++;
         check_flag("dma_pkt_ready_o", (accepted - addr_started) < `DA_QUEUE_DEPTH,
                    dma_pkt_ready_o);
         if (dma_pkt_v_i && dma_pkt_ready_o)
            accepted++;
         addr_v_d = m_axi_awvalid_o | m_axi_arvalid_o;
         if ((m_axi_bvalid_i && m_axi_bready_o && m_axi_bresp_i != 0) ||
             (m_axi_rvalid_i && m_axi_rready_o && m_axi_rresp_i != 0))
            bad_seen = 1;
         cycles++;
         if (cycles > LIMIT)
         begin
            $display("run timed out before all bursts completed");
            $display("SOME TESTS FAILED");
            $fatal(1);
         end
      end
   end

   initial
   begin
      wait (bursts_done == N_ENT && reads_done == 1);
      repeat (2) @(posedge clk);
      check_flag("err_o", 1'b1, err_o);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* dma_axi_assert.sv */
// Bridge protocol assertions
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module dma_axi_assert
(
   input logic                  clk_i,
   input logic                  rst_n_i,
   input logic                  m_axi_awvalid_o,
   input logic                  m_axi_awready_i,
   input logic [`DA_ADDR_W-1:0] m_axi_awaddr_o,
   input logic                  m_axi_arvalid_o,
   input logic                  m_axi_arready_i,
   input logic                  m_axi_wvalid_o,
   input logic                  m_axi_wready_i,
   input logic                  m_axi_wlast_o,
   input logic                  m_axi_rvalid_i,
   input logic                  m_axi_rready_o,
   input logic                  m_axi_rlast_i,
   input logic                  dma_rdata_v_o
);
   localparam int BEAT_W = $clog2(`DA_BEATS);

   logic              read_open;
   logic [BEAT_W-1:0] w_beat;

   // Open from the cycle after AR transfer until the rlast beat
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         read_open <= 1'b0;
      else if (m_axi_arvalid_o && m_axi_arready_i)
         read_open <= 1'b1;
      else if (m_axi_rvalid_i && m_axi_rready_o && m_axi_rlast_i)
         read_open <= 1'b0;
   end

   // W beats taken so far in the open burst
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         w_beat <= '0;
      else if (m_axi_wvalid_o && m_axi_wready_i)
         w_beat <= w_beat + 1'b1;
   end

   aw_ar_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(m_axi_awvalid_o && m_axi_arvalid_o))
      else $error("AW and AR valid together");

   aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_awvalid_o && !m_axi_awready_i |=>
         m_axi_awvalid_o && $stable(m_axi_awaddr_o))
      else $error("AW dropped or changed before awready");

   wlast_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_wlast_o |-> m_axi_wvalid_o && (w_beat == BEAT_W'(`DA_BEATS - 1)))
      else $error("wlast without wvalid or off the last beat");

   rdata_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dma_rdata_v_o |-> read_open)
      else $error("read data outside a read burst");

endmodule

bind dma_axi_top dma_axi_assert dma_axi_assert_inst
(
   .clk_i           (clk_i),
   .rst_n_i         (rst_n_i),
   .m_axi_awvalid_o (m_axi_awvalid_o),
   .m_axi_awready_i (m_axi_awready_i),
   .m_axi_awaddr_o  (m_axi_awaddr_o),
   .m_axi_arvalid_o (m_axi_arvalid_o),
   .m_axi_arready_i (m_axi_arready_i),
   .m_axi_wvalid_o  (m_axi_wvalid_o),
   .m_axi_wready_i  (m_axi_wready_i),
   .m_axi_wlast_o   (m_axi_wlast_o),
   .m_axi_rvalid_i  (m_axi_rvalid_i),
   .m_axi_rready_o  (m_axi_rready_o),
   .m_axi_rlast_i   (m_axi_rlast_i),
   .dma_rdata_v_o   (dma_rdata_v_o)
);

/* tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk_o,
   output logic rst_n_o
);
   initial
   begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   // Reset held for 10 cycles
   initial
   begin
      rst_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* dma_axi_top.sv */
// Cache DMA to AXI4 bridge
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module dma_axi_top
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   input  logic                    dma_pkt_v_i,
   input  logic                    dma_pkt_write_not_read_i,
   input  dma_axi_pkg::dram_addr_u dma_pkt_addr_i,
   input  logic [`DA_BEATS-1:0]    dma_pkt_mask_i,
   output logic                    dma_pkt_ready_o,

   input  logic                    dma_wdata_v_i,
   input  logic [`DA_DATA_W-1:0]   dma_wdata_i,
   output logic                    dma_wdata_ready_o,

   output logic                    dma_rdata_v_o,
   output logic [`DA_DATA_W-1:0]   dma_rdata_o,
   input  logic                    dma_rdata_ready_i,

   output logic                    err_o,

   output logic [`DA_ADDR_W-1:0]   m_axi_awaddr_o,
   output logic                    m_axi_awvalid_o,
   input  logic                    m_axi_awready_i,

   output logic [`DA_DATA_W-1:0]   m_axi_wdata_o,
   output logic [`DA_STRB_W-1:0]   m_axi_wstrb_o,
   output logic                    m_axi_wlast_o,
   output logic                    m_axi_wvalid_o,
   input  logic                    m_axi_wready_i,

   input  logic [1:0]              m_axi_bresp_i,
   input  logic                    m_axi_bvalid_i,
   output logic                    m_axi_bready_o,

   output logic [`DA_ADDR_W-1:0]   m_axi_araddr_o,
   output logic                    m_axi_arvalid_o,
   input  logic                    m_axi_arready_i,

   input  logic [`DA_DATA_W-1:0]   m_axi_rdata_i,
   input  logic [1:0]              m_axi_rresp_i,
   input  logic                    m_axi_rlast_i,
   input  logic                    m_axi_rvalid_i,
   output logic                    m_axi_rready_o
);
   import dma_axi_pkg::*;

   logic                 q_v;
   logic                 q_write_not_read;
   dram_addr_u           q_addr;
   logic [`DA_BEATS-1:0] q_mask;
   logic                 q_pop;
   logic                 wr_start;
   logic [`DA_BEATS-1:0] wr_mask;
   logic                 wr_done;
   logic                 wr_err;
   logic                 rd_start;
   logic                 rd_done;
   logic                 rd_err;

   dma_pkt_queue dma_pkt_queue_inst
   (
      .clk_i                 (clk_i),
      .rst_n_i               (rst_n_i),
      .pkt_v_i               (dma_pkt_v_i),
      .pkt_write_not_read_i  (dma_pkt_write_not_read_i),
      .pkt_mask_i            (dma_pkt_mask_i),
      .pkt_addr_i            (dma_pkt_addr_i),
      .pkt_ready_o           (dma_pkt_ready_o),
      .head_v_o              (q_v),
      .head_write_not_read_o (q_write_not_read),
      .head_mask_o           (q_mask),
      .head_addr_o           (q_addr),
      .pop_i                 (q_pop)
   );

   // AW and AR ports share names with the top
   axi_burst_ctrl axi_burst_ctrl_inst
   (
      .head_v_i              (q_v),
      .head_write_not_read_i (q_write_not_read),
      .head_mask_i           (q_mask),
      .head_addr_i           (q_addr),
      .pop_o                 (q_pop),
      .wr_start_o            (wr_start),
      .wr_mask_o             (wr_mask),
      .wr_done_i             (wr_done),
      .rd_start_o            (rd_start),
      .rd_done_i             (rd_done),
      .*
   );

   axi_write_beats axi_write_beats_inst
   (
      .start_i (wr_start),
      .mask_i  (wr_mask),
      .done_o  (wr_done),
      .err_o   (wr_err),
      .*
   );

   axi_read_beats axi_read_beats_inst
   (
      .start_i (rd_start),
      .done_o  (rd_done),
      .err_o   (rd_err),
      .*
   );

   assign err_o = wr_err | rd_err;

endmodule

/* axi_read_beats.sv */
// AXI read beat engine
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module axi_read_beats
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  logic [`DA_DATA_W-1:0] m_axi_rdata_i,
   input  logic [1:0]            m_axi_rresp_i,
   input  logic                  m_axi_rlast_i,
   input  logic                  m_axi_rvalid_i,
   output logic                  m_axi_rready_o,
   output logic [`DA_DATA_W-1:0] dma_rdata_o,
   output logic                  dma_rdata_v_o,
   input  logic                  dma_rdata_ready_i,
   output logic                  done_o,
   output logic                  err_o
);
   logic active;
   logic r_fire;

   // R channel only open during a read burst
   assign m_axi_rready_o = active & dma_rdata_ready_i;
   assign dma_rdata_v_o  = active & m_axi_rvalid_i;
   assign dma_rdata_o    = m_axi_rdata_i;
   assign r_fire         = dma_rdata_v_o & dma_rdata_ready_i;
   assign done_o         = r_fire & m_axi_rlast_i;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         active <= 1'b0;
         err_o  <= 1'b0;
      end
      else
      begin
         if (start_i)
            active <= 1'b1;
         else if (done_o)
            active <= 1'b0;
         // Any bad beat flags the whole run
         if (r_fire && (m_axi_rresp_i != 2'b00))
            err_o <= 1'b1;
      end
   end

endmodule

/* axi_write_beats.sv */
// AXI write beat engine
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module axi_write_beats
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  logic [`DA_BEATS-1:0]  mask_i,
   input  logic                  dma_wdata_v_i,
   input  logic [`DA_DATA_W-1:0] dma_wdata_i,
   output logic                  dma_wdata_ready_o,
   output logic [`DA_DATA_W-1:0] m_axi_wdata_o,
   output logic [`DA_STRB_W-1:0] m_axi_wstrb_o,
   output logic                  m_axi_wvalid_o,
   output logic                  m_axi_wlast_o,
   input  logic                  m_axi_wready_i,
   input  logic [1:0]            m_axi_bresp_i,
   input  logic                  m_axi_bvalid_i,
   output logic                  m_axi_bready_o,
   output logic                  done_o,
   output logic                  err_o
);
   localparam int CNT_W = $clog2(`DA_BEATS);

   logic                 sending;
   logic                 wait_b;
   logic [CNT_W-1:0]     beat_cnt;
   logic [`DA_BEATS-1:0] mask_r;
   logic                 last_beat;
   logic                 w_fire;
   logic                 b_fire;

   assign last_beat = (beat_cnt == CNT_W'(`DA_BEATS - 1));

   // Cache data goes straight onto W while beats are open
   assign dma_wdata_ready_o = sending & m_axi_wready_i;
   assign m_axi_wvalid_o    = sending & dma_wdata_v_i;
   assign m_axi_wdata_o     = dma_wdata_i;
   assign m_axi_wstrb_o     = {`DA_STRB_W{mask_r[beat_cnt]}};
   assign m_axi_wlast_o     = m_axi_wvalid_o & last_beat;
   assign w_fire            = m_axi_wvalid_o & m_axi_wready_i;

   assign m_axi_bready_o = wait_b;
   assign b_fire         = m_axi_bvalid_i & wait_b;
   assign done_o         = b_fire;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         sending  <= 1'b0;
         wait_b   <= 1'b0;
         beat_cnt <= '0;
         err_o    <= 1'b0;
      end
      else
      begin
         if (start_i)
         begin
            sending  <= 1'b1;
            beat_cnt <= '0;
         end
         else if (w_fire)
         begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat)
            begin
               sending <= 1'b0;
               wait_b  <= 1'b1;
            end
         end
         if (b_fire)
         begin
            wait_b <= 1'b0;
            // Sticky until reset
            if (m_axi_bresp_i != 2'b00)
               err_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (start_i)
         mask_r <= mask_i;
   end

endmodule

/* axi_burst_ctrl.sv */
// AXI burst controller with DRAM address unhash
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module axi_burst_ctrl
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    head_v_i,
   input  logic                    head_write_not_read_i,
   input  logic [`DA_BEATS-1:0]    head_mask_i,
   input  dma_axi_pkg::dram_addr_u head_addr_i,
   output logic                    pop_o,
   output logic [`DA_ADDR_W-1:0]   m_axi_awaddr_o,
   output logic                    m_axi_awvalid_o,
   input  logic                    m_axi_awready_i,
   output logic [`DA_ADDR_W-1:0]   m_axi_araddr_o,
   output logic                    m_axi_arvalid_o,
   input  logic                    m_axi_arready_i,
   output logic                    wr_start_o,
   output logic [`DA_BEATS-1:0]    wr_mask_o,
   input  logic                    wr_done_i,
   output logic                    rd_start_o,
   input  logic                    rd_done_i
);
   import dma_axi_pkg::*;

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_ADDR    = 2'd1;
   localparam logic [1:0] ST_WR_WAIT = 2'd2;
   localparam logic [1:0] ST_RD_WAIT = 2'd3;

   logic [1:0]           state;
   dram_addr_u           addr_unhash;
   dram_addr_u           addr_r;
   logic                 wnr_r;
   logic [`DA_BEATS-1:0] mask_r;
   logic                 aw_fire;
   logic                 ar_fire;

   // Bank taken back from the low row bits, block aligned
   always_comb
   begin
      addr_unhash              = head_addr_i;
      addr_unhash.field.bank   = head_addr_i.field.bank
                                 ^ head_addr_i.field.row[`DA_BANK_W-1:0];
      addr_unhash.field.offset = '0;
   end

   assign pop_o = (state == ST_IDLE) & head_v_i;

   assign m_axi_awvalid_o = (state == ST_ADDR) & wnr_r;
   assign m_axi_arvalid_o = (state == ST_ADDR) & ~wnr_r;
   assign m_axi_awaddr_o  = addr_r.flat;
   assign m_axi_araddr_o  = addr_r.flat;
   assign aw_fire         = m_axi_awvalid_o & m_axi_awready_i;
   assign ar_fire         = m_axi_arvalid_o & m_axi_arready_i;
   assign wr_mask_o       = mask_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state      <= ST_IDLE;
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
      end
      else
      begin
         // Engines start the cycle after the address transfer
         wr_start_o <= aw_fire;
         rd_start_o <= ar_fire;
         case (state)
            ST_IDLE:
               if (head_v_i)
                  state <= ST_ADDR;
            ST_ADDR:
               if (aw_fire)
                  state <= ST_WR_WAIT;
               else if (ar_fire)
                  state <= ST_RD_WAIT;
            ST_WR_WAIT:
               if (wr_done_i)
                  state <= ST_IDLE;
            default:
               if (rd_done_i)
                  state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (pop_o)
      begin
         addr_r <= addr_unhash;
         wnr_r  <= head_write_not_read_i;
         mask_r <= head_mask_i;
      end
   end

endmodule

/* dma_pkt_queue.sv */
// DMA packet queue
`timescale 1ns/1ps
`include "dma_axi_cfg.svh"

module dma_pkt_queue
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    pkt_v_i,
   input  logic                    pkt_write_not_read_i,
   input  logic [`DA_BEATS-1:0]    pkt_mask_i,
   input  dma_axi_pkg::dram_addr_u pkt_addr_i,
   output logic                    pkt_ready_o,
   output logic                    head_v_o,
   output logic                    head_write_not_read_o,
   output logic [`DA_BEATS-1:0]    head_mask_o,
   output dma_axi_pkg::dram_addr_u head_addr_o,
   input  logic                    pop_i
);
   import dma_axi_pkg::*;

   localparam int PTR_W = $clog2(`DA_QUEUE_DEPTH);
   localparam int CNT_W = $clog2(`DA_QUEUE_DEPTH + 1);

   logic                 wnr_mem  [`DA_QUEUE_DEPTH];
   logic [`DA_BEATS-1:0] mask_mem [`DA_QUEUE_DEPTH];
   dram_addr_u           addr_mem [`DA_QUEUE_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;
   logic                 push;
   logic                 pop;

   assign pkt_ready_o = (count < CNT_W'(`DA_QUEUE_DEPTH));
   assign head_v_o    = (count != '0);
   assign push        = pkt_v_i & pkt_ready_o;
   assign pop         = pop_i & head_v_o;

   assign head_write_not_read_o = wnr_mem[rd_ptr];
   assign head_mask_o           = mask_mem[rd_ptr];
   assign head_addr_o           = addr_mem[rd_ptr];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(`DA_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(`DA_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // Push with pop leaves the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         wnr_mem[wr_ptr]  <= pkt_write_not_read_i;
         mask_mem[wr_ptr] <= pkt_mask_i;
         addr_mem[wr_ptr] <= pkt_addr_i;
      end
   end

endmodule

/* dma_axi_pkg.sv */
// DMA to AXI bridge types
`include "dma_axi_cfg.svh"

package dma_axi_pkg;

   // Flat byte address, or the DRAM row/bank/offset view of it
   typedef union packed
   {
      logic [`DA_ADDR_W-1:0] flat;
      struct packed
      {
         logic [`DA_ROW_W-1:0]    row;
         logic [`DA_BANK_W-1:0]   bank;
         logic [`DA_OFFSET_W-1:0] offset;
      } field;
   } dram_addr_u;

endpackage

/* dma_axi_cfg.svh */
// DMA to AXI bridge sizes
`ifndef DMA_AXI_CFG_SVH
`define DMA_AXI_CFG_SVH

// Byte address carried on DMA and AXI
`define DA_ADDR_W 28

// DRAM address fields, lowest to highest
`define DA_OFFSET_W 6
`define DA_BANK_W 3
`define DA_ROW_W 19

// Beat shape
`define DA_DATA_W 64
`define DA_STRB_W 8

// One 64-byte block per burst, one mask bit per beat
`define DA_BEATS 8

// Packets held ahead of the open burst
`define DA_QUEUE_DEPTH 2

`endif
